//--- sources.f
design/primitivePkg.sv
design/queryLatch.sv
design/primitiveStore.sv
design/aabbDecoder.sv
design/sphereDecoder.sv
design/resultRegister.sv
design/primitiveUnit.sv
test/primitiveUnitTb.sv

//--- run.sh
#!/bin/sh
# Build the primitive unit testbench with Verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/primitiveUnitSim

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module primitiveUnitTb -f sources.f \
        -Mdir obj_dir -o primitiveUnitSim; then
    echo "Verilator build failed"
    exit 1
fi

./$SIM > "$LOG" 2>&1
runStatus=$?
cat "$LOG"

if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
exit 0

//--- test/primitiveUnitTb.sv
`timescale 1ns/1ps
// Testbench for the primitive unit
// Reference scene model, two-cycle expectation queue, compare tasks
// Directed and random box and sphere queries
module primitiveUnitTb import primitivePkg::*; ();

    // Inputs seen by the DUT in one cycle
    typedef struct packed {
        queryT  aabbQ;
        queryT  sphereQ;
        fixed3T off;
    } stimT;

    // Scene rows: center x, y, z, half-size or radius, red, green, blue
    localparam int boxRows [4][7] = '{
        '{0, -256, 0, 256, 100, 255, 100},
        '{0, 12, 24, 12, 255, 255, 145},
        '{-25, 12, 0, 12, 255, 70, 85},
        '{0, 0, 0, 0, 0, 0, 0}
    };
    localparam int sphereRows [2][7] = '{
        '{0, 16, 0, 16, 255, 255, 0},
        '{0, 0, 0, 0, 0, 0, 0}
    };

    logic       clk;
    logic       rstN;
    fixed3T     offset;
    queryT      aabbQuery;
    queryT      sphereQuery;
    aabbPrimT   aabbPrim [aabbLanes];
    spherePrimT spherePrim [sphereLanes];

    stimT stimQ [$];
    logic checking;
    logic timedOut;
    int   seed;
    int   errorCount;
    int   checkCount;
    int   compared;
    int   testsRun;
    int   testsFailed;
    int   errorsAtStart;

    primitiveUnit UUT (
        .clk        (clk),
        .rstN       (rstN),
        .offset     (offset),
        .aabbQuery  (aabbQuery),
        .sphereQuery(sphereQuery),
        .aabbPrim   (aabbPrim),
        .spherePrim (spherePrim)
    );

    always #5 clk = ~clk;

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic fixedT toFixed(input int v);
        return fixedT'(v * 65536);
    endfunction

    // Glass at 1, mirror at 2, diffuse elsewhere
    function automatic surfaceT expectedSurface(input logic [indexWidth-1:0] idx);
        if (idx == 8'd1) return dielectric;
        if (idx == 8'd2) return metal;
        return lambertian;
    endfunction

    function automatic aabbPrimT refAabb(input queryT q, input fixed3T off, input int lane);
        aabbPrimT              p;
        logic [indexWidth-1:0] idx;
        int                    row [7];
        fixed3T                c;
        fixed3T                s;
        fixedT                 h;
        idx       = q.startIndex + 8'(lane);
        p         = '0;
        p.surface = lambertian;
        p.index   = nullIndex;
        // Rejected lane: box collapses onto the offset
        if (idx[indexWidth-1] || idx >= q.endIndex) begin
            p.box.minCorner = off;
            p.box.maxCorner = off;
            return p;
        end
        // Past the table reads as zero
        for (int k = 0; k < 7; k++) begin
            row[k] = 0;
            if (idx < 8'd4) row[k] = boxRows[idx[1:0]][k];
        end
        c.x = toFixed(row[0]);
        c.y = toFixed(row[1]);
        c.z = toFixed(row[2]);
        h   = toFixed(row[3]);
        s   = (idx == 8'd1) ? off : '0;
        p.box.minCorner.x = c.x - h + s.x;
        p.box.minCorner.y = c.y - h + s.y;
        p.box.minCorner.z = c.z - h + s.z;
        p.box.maxCorner.x = c.x + h + s.x;
        p.box.maxCorner.y = c.y + h + s.y;
        p.box.maxCorner.z = c.z + h + s.z;
        p.color.r = 8'(row[4]);
        p.color.g = 8'(row[5]);
        p.color.b = 8'(row[6]);
        p.surface = expectedSurface(idx);
        p.index   = idx;
        return p;
    endfunction

    function automatic spherePrimT refSphere(input queryT q, input int lane);
        spherePrimT            p;
        logic [indexWidth-1:0] idx;
        int                    row [7];
        idx       = q.startIndex + 8'(lane);
        p         = '0;
        p.surface = lambertian;
        p.index   = nullIndex;
        if (idx[indexWidth-1] || idx >= q.endIndex) return p;
        for (int k = 0; k < 7; k++) begin
            row[k] = 0;
            if (idx < 8'd2) row[k] = sphereRows[idx[0]][k];
        end
        p.center.x = toFixed(row[0]);
        p.center.y = toFixed(row[1]);
        p.center.z = toFixed(row[2]);
        p.radius   = toFixed(row[3]);
        p.color.r  = 8'(row[4]);
        p.color.g  = 8'(row[5]);
        p.color.b  = 8'(row[6]);
        p.surface  = expectedSurface(idx);
        p.index    = idx;
        return p;
    endfunction

    // ----------------------------------------
    // Compare tasks and process
    // ----------------------------------------
    task automatic checkAabb(input string name, input aabbPrimT got, input aabbPrimT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR at %0d ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkSphere(input string name, input spherePrimT got, input spherePrimT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR at %0d ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Inputs of this cycle come out two edges later
    always @(negedge clk) begin
        stimT s;
        if (checking) begin
            if (stimQ.size() >= 2) begin
                s = stimQ.pop_front();
                for (int l = 0; l < aabbLanes; l++) begin
                    checkAabb($sformatf("aabbPrim[%0d]", l), aabbPrim[l],
                              refAabb(s.aabbQ, s.off, l));
                end
                for (int l = 0; l < sphereLanes; l++) begin
                    checkSphere($sformatf("spherePrim[%0d]", l), spherePrim[l],
                                refSphere(s.sphereQ, l));
                end
                compared++;
            end
            stimQ.push_back({aabbQuery, sphereQuery, offset});
        end
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    function automatic queryT makeQuery(input logic [7:0] start, input logic [7:0] bound);
        queryT q;
        q.startIndex = start;
        q.endIndex   = bound;
        return q;
    endfunction

    task automatic applyQuery(input queryT a, input queryT s, input fixed3T off);
        @(posedge clk);
        aabbQuery   <= a;
        sphereQuery <= s;
        offset      <= off;
    endtask

    // Last applied query is compared on the third negedge
    task automatic waitForChecks(input int count);
        int target;
        int cycles;
        target = compared + count;
        cycles = 0;
        while (compared < target && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (compared < target) begin
            $display("Timeout: results stopped arriving, %0d of %0d compares done",
                     compared, target);
            timedOut = 1'b1;
        end
    endtask

    task automatic finishTest(input string name);
        int errs;
        errs = errorCount - errorsAtStart;
        testsRun++;
        if (errs != 0 || timedOut) begin
            testsFailed++;
            $display("Test %0d %s: FAILED with %0d mismatches", testsRun, name, errs);
        end else begin
            $display("Test %0d %s: ok", testsRun, name);
        end
        errorsAtStart = errorCount;
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        aabbPrimT   nullBox;
        spherePrimT nullBall;
        fixed3T     off;
        queryT      a;
        queryT      s;
        int         r;
        clk           = 1'b0;
        rstN          = 1'b0;
        offset        = '0;
        aabbQuery     = '0;
        sphereQuery   = '0;
        checking      = 1'b0;
        timedOut      = 1'b0;
        seed          = 32'hadd741d4;
        errorCount    = 0;
        checkCount    = 0;
        compared      = 0;
        testsRun      = 0;
        testsFailed   = 0;
        errorsAtStart = 0;
        repeat (2) @(posedge clk);
        rstN     <= 1'b1;
        checking = 1'b1;

        // Null records straight out of reset
        nullBox          = '0;
        nullBox.surface  = lambertian;
        nullBox.index    = nullIndex;
        nullBall         = '0;
        nullBall.surface = lambertian;
        nullBall.index   = nullIndex;
        repeat (2) begin
            @(negedge clk);
            for (int l = 0; l < aabbLanes; l++) begin
                checkAabb($sformatf("aabbPrim[%0d]", l), aabbPrim[l], nullBox);
            end
            for (int l = 0; l < sphereLanes; l++) begin
                checkSphere($sformatf("spherePrim[%0d]", l), spherePrim[l], nullBall);
            end
        end
        finishTest("reset null lanes");

        // Ground, glass box with offset, then mirror box and a null lane
        off.x = 32'sh0001_8000;
        off.y = -32'sd131072;
        off.z = 32'sh0003_0000;
        applyQuery(makeQuery(8'd0, 8'd3), makeQuery(8'd0, 8'd0), off);
        applyQuery(makeQuery(8'd2, 8'd3), makeQuery(8'd0, 8'd0), off);
        waitForChecks(3);
        finishTest("box entries and surfaces");

        // Bound and top-bit rejection, beyond-table reads
        if (!timedOut) begin
            off.x = -32'sd40000;
            off.y = 32'sh0010_0000;
            off.z = 32'sd7;
            applyQuery(makeQuery(8'd1, 8'd1), makeQuery(8'd1, 8'd1), off);
            applyQuery(makeQuery(8'd3, 8'd10), makeQuery(8'd1, 8'd9), off);
            applyQuery(makeQuery(8'h7f, 8'hff), makeQuery(8'h7f, 8'hff), off);
            applyQuery(makeQuery(8'h90, 8'hff), makeQuery(8'h80, 8'hff), off);
            waitForChecks(3);
            finishTest("out of range lanes");
        end

        if (!timedOut) begin
            applyQuery(makeQuery(8'd0, 8'd0), makeQuery(8'd0, 8'd2), off);
            waitForChecks(3);
            finishTest("sphere entries");
        end

        // New query and offset every cycle
        if (!timedOut) begin
            repeat (64) begin
                r = $random(seed);
                a = makeQuery(r[3] ? r[15:8] : {5'd0, r[2:0]},
                              r[4] ? r[23:16] : {4'd0, r[7:5], 1'b1});
                r = $random(seed);
                s = makeQuery(r[3] ? r[15:8] : {6'd0, r[1:0]},
                              r[4] ? r[23:16] : {5'd0, r[7:5]});
                off.x = $random(seed);
                off.y = $random(seed);
                off.z = $random(seed);
                applyQuery(a, s, off);
            end
            waitForChecks(3);
            finishTest("random back to back");
        end

        $display("Tests run %0d, tests failing %0d, checks %0d, mismatches %0d",
                 testsRun, testsFailed, checkCount, errorCount);
        if (errorCount == 0 && testsFailed == 0 && !timedOut && checkCount > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- design/primitiveUnit.sv
`timescale 1ns/1ps
// Primitive unit top level
// Query stage, scene tables, per-lane decoders, result stage
module primitiveUnit import primitivePkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  fixed3T     offset,
    input  queryT      aabbQuery,
    input  queryT      sphereQuery,
    output aabbPrimT   aabbPrim [aabbLanes],
    output spherePrimT spherePrim [sphereLanes]
);

    fixed3T                offsetQ;
    logic [indexWidth-1:0] aabbIndex [aabbLanes];
    logic [indexWidth-1:0] sphereIndex [sphereLanes];
    logic [rawWidth-1:0]   aabbRaw [aabbLanes];
    logic [rawWidth-1:0]   sphereRaw [sphereLanes];
    aabbPrimT              aabbDecoded [aabbLanes];
    spherePrimT            sphereDecoded [sphereLanes];

    // Cycle 1: sample queries
    queryLatch queryStage (
        .clk        (clk),
        .rstN       (rstN),
        .offset     (offset),
        .aabbQuery  (aabbQuery),
        .sphereQuery(sphereQuery),
        .offsetQ    (offsetQ),
        .aabbIndex  (aabbIndex),
        .sphereIndex(sphereIndex)
    );

    primitiveStore store (
        .aabbIndex  (aabbIndex),
        .sphereIndex(sphereIndex),
        .aabbRaw    (aabbRaw),
        .sphereRaw  (sphereRaw)
    );

    for (genvar l = 0; l < aabbLanes; l++) begin : gAabbLane
        aabbDecoder decoder (
            .index (aabbIndex[l]),
            .raw   (aabbRaw[l]),
            .offset(offsetQ),
            .prim  (aabbDecoded[l])
        );
    end

    for (genvar l = 0; l < sphereLanes; l++) begin : gSphereLane
        sphereDecoder decoder (
            .index(sphereIndex[l]),
            .raw  (sphereRaw[l]),
            .prim (sphereDecoded[l])
        );
    end

    // Cycle 2: decoded lanes to the ports
    resultRegister results (
        .clk       (clk),
        .rstN      (rstN),
        .aabbIn    (aabbDecoded),
        .sphereIn  (sphereDecoded),
        .aabbPrim  (aabbPrim),
        .spherePrim(spherePrim)
    );

endmodule

//--- design/resultRegister.sv
`timescale 1ns/1ps
// Output stage: registers decoded box and sphere lanes
// Null records after reset
module resultRegister import primitivePkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  aabbPrimT   aabbIn [aabbLanes],
    input  spherePrimT sphereIn [sphereLanes],
    output aabbPrimT   aabbPrim [aabbLanes],
    output spherePrimT spherePrim [sphereLanes]
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int l = 0; l < aabbLanes; l++) begin
                aabbPrim[l] <= nullAabbPrim;
            end
            for (int l = 0; l < sphereLanes; l++) begin
                spherePrim[l] <= nullSpherePrim;
            end
        end else begin
            aabbPrim   <= aabbIn;
            spherePrim <= sphereIn;
        end
    end

    // Null lanes never carry a color, whichever table entry was read
    for (genvar l = 0; l < aabbLanes; l++) begin : gAabbCheck
        aabbNullDark: assert property (@(posedge clk) disable iff (!rstN)
            aabbPrim[l].index == nullIndex |-> aabbPrim[l].color == '0);
    end

    for (genvar l = 0; l < sphereLanes; l++) begin : gSphereCheck
        sphereNullDark: assert property (@(posedge clk) disable iff (!rstN)
            spherePrim[l].index == nullIndex |-> spherePrim[l].color == '0);
    end

endmodule

//--- design/sphereDecoder.sv
`timescale 1ns/1ps
// Sphere lane decoder
// Center, radius, color, surface type and index from one record
module sphereDecoder import primitivePkg::*; (
    input  logic [indexWidth-1:0] index,
    input  logic [rawWidth-1:0]   raw,
    output spherePrimT            prim
);

    logic isNull;

    assign isNull = (index == nullIndex);

    always_comb begin
        if (isNull) begin
            // Empty sphere, nothing to hit
            prim.center  = '0;
            prim.radius  = '0;
            prim.color   = '0;
            prim.surface = lambertian;
        end else begin
            // Same record layout as the box table
            prim.center  = raw[rawWidth-1 -: $bits(fixed3T)];
            prim.radius  = raw[$bits(rgb8T) +: fixedWidth];
            prim.color   = raw[$bits(rgb8T)-1:0];
            prim.surface = surfaceOf(index);
        end
        prim.index = index;
    end

endmodule

//--- design/aabbDecoder.sv
`timescale 1ns/1ps
// Box lane decoder
// Corners from center and half-size, global offset, color, surface, index
module aabbDecoder import primitivePkg::*; (
    input  logic [indexWidth-1:0] index,
    input  logic [rawWidth-1:0]   raw,
    input  fixed3T                offset,
    output aabbPrimT              prim
);

    fixed3T center;
    fixedT  halfSize;
    rgb8T   color;
    fixed3T shift;
    logic   isNull;

    assign isNull = (index == nullIndex);

    // Record fields, zeroed for a null lane since the store returns entry 0
    always_comb begin
        if (isNull) begin
            center   = '0;
            halfSize = '0;
            color    = '0;
        end else begin
            center   = raw[rawWidth-1 -: $bits(fixed3T)];
            halfSize = raw[$bits(rgb8T) +: fixedWidth];
            color    = raw[$bits(rgb8T)-1:0];
        end
    end

    // Offset moves the one movable box; a null box collapses onto it
    always_comb begin
        if (isNull || index == movedBoxIndex) begin
            shift = offset;
        end else begin
            shift = '0;
        end
    end

    always_comb begin
        prim.box.minCorner.x = center.x - halfSize + shift.x;
        prim.box.minCorner.y = center.y - halfSize + shift.y;
        prim.box.minCorner.z = center.z - halfSize + shift.z;
        prim.box.maxCorner.x = center.x + halfSize + shift.x;
        prim.box.maxCorner.y = center.y + halfSize + shift.y;
        prim.box.maxCorner.z = center.z + halfSize + shift.z;
        prim.color           = color;
        prim.surface         = isNull ? lambertian : surfaceOf(index);
        prim.index           = index;
    end

endmodule

//--- design/primitiveStore.sv
`timescale 1ns/1ps
// Read-only box and sphere tables holding the built-in scene
// One combinational read port per lane
module primitiveStore import primitivePkg::*; (
    input  logic [indexWidth-1:0] aabbIndex [aabbLanes],
    input  logic [indexWidth-1:0] sphereIndex [sphereLanes],
    output logic [rawWidth-1:0]   aabbRaw [aabbLanes],
    output logic [rawWidth-1:0]   sphereRaw [sphereLanes]
);

    logic [rawWidth-1:0] aabbTable [aabbCount];
    logic [rawWidth-1:0] sphereTable [sphereCount];

    // ----------------------------------------
    // Table fill
    // ----------------------------------------
    // Integers to Q16.16, packed center first, color last
    function automatic logic [rawWidth-1:0] packRecord(
        input int x,
        input int y,
        input int z,
        input int size,
        input int r,
        input int g,
        input int b
    );
        fixed3T center;
        fixedT  scale;
        rgb8T   color;
        center.x = fixedT'(x <<< fracWidth);
        center.y = fixedT'(y <<< fracWidth);
        center.z = fixedT'(z <<< fracWidth);
        scale    = fixedT'(size <<< fracWidth);
        color.r  = 8'(r);
        color.g  = 8'(g);
        color.b  = 8'(b);
        return {center, scale, color};
    endfunction

    initial begin
        for (int i = 0; i < aabbCount; i++) begin
            aabbTable[i] = packRecord(aabbScene[i][0], aabbScene[i][1], aabbScene[i][2],
                                      aabbScene[i][3], aabbScene[i][4], aabbScene[i][5],
                                      aabbScene[i][6]);
        end
        for (int i = 0; i < sphereCount; i++) begin
            sphereTable[i] = packRecord(sphereScene[i][0], sphereScene[i][1],
                                        sphereScene[i][2], sphereScene[i][3],
                                        sphereScene[i][4], sphereScene[i][5],
                                        sphereScene[i][6]);
        end
    end

    // ----------------------------------------
    // Lane reads
    // ----------------------------------------
    // Null lanes clamp to entry 0, valid indices past the table read zero
    for (genvar l = 0; l < aabbLanes; l++) begin : gAabbRead
        logic [indexWidth-1:0] addr;
        assign addr = (aabbIndex[l] == nullIndex) ? '0 : aabbIndex[l];
        assign aabbRaw[l] = (addr < aabbCount) ? aabbTable[addr[aabbAddrWidth-1:0]] : '0;
    end

    for (genvar l = 0; l < sphereLanes; l++) begin : gSphereRead
        logic [indexWidth-1:0] addr;
        assign addr = (sphereIndex[l] == nullIndex) ? '0 : sphereIndex[l];
        assign sphereRaw[l] = (addr < sphereCount) ?
                              sphereTable[addr[sphereAddrWidth-1:0]] : '0;
    end

endmodule

//--- design/queryLatch.sv
`timescale 1ns/1ps
// Input stage registering the queries and the offset
// Lane index forming with range and top-bit check
module queryLatch import primitivePkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  fixed3T                offset,
    input  queryT                 aabbQuery,
    input  queryT                 sphereQuery,
    output fixed3T                offsetQ,
    output logic [indexWidth-1:0] aabbIndex [aabbLanes],
    output logic [indexWidth-1:0] sphereIndex [sphereLanes]
);

    queryT aabbQ;
    queryT sphereQ;

    // Empty range after reset leaves every lane null
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            aabbQ   <= '0;
            sphereQ <= '0;
            offsetQ <= '0;
        end else begin
            aabbQ   <= aabbQuery;
            sphereQ <= sphereQuery;
            // Offset travels with its query
            offsetQ <= offset;
        end
    end

    // Start plus lane wraps at the index width
    function automatic logic [indexWidth-1:0] laneIndex(input queryT q, input int lane);
        logic [indexWidth-1:0] idx;
        idx = q.startIndex + indexWidth'(lane);
        if (!idx[indexWidth-1] && idx < q.endIndex) begin
            return idx;
        end
        return nullIndex;
    endfunction

    // Valid lanes stay below the bound sampled one cycle earlier
    for (genvar l = 0; l < aabbLanes; l++) begin : gAabbLane
        assign aabbIndex[l] = laneIndex(aabbQ, l);
        aabbBelowBound: assert property (@(posedge clk) disable iff (!rstN)
            aabbIndex[l] != nullIndex |-> aabbIndex[l] < $past(aabbQuery.endIndex));
    end

    for (genvar l = 0; l < sphereLanes; l++) begin : gSphereLane
        assign sphereIndex[l] = laneIndex(sphereQ, l);
        sphereBelowBound: assert property (@(posedge clk) disable iff (!rstN)
            sphereIndex[l] != nullIndex |-> sphereIndex[l] < $past(sphereQuery.endIndex));
    end

endmodule

//--- design/primitivePkg.sv
// Widths, built-in scene and fixed-point types of the primitive unit
// Decoded box and sphere records, null records, surface-type rule
package primitivePkg;

    // ----------------------------------------
    // Widths and sizes
    // ----------------------------------------
    // Q16.16 fixed point
    localparam int fixedWidth = 32;
    localparam int fracWidth  = 16;
    localparam int indexWidth = 8;
    localparam logic [indexWidth-1:0] nullIndex = '1;

    localparam int aabbLanes       = 2;
    localparam int sphereLanes     = 2;
    localparam int aabbCount       = 4;
    localparam int sphereCount     = 2;
    localparam int aabbAddrWidth   = $clog2(aabbCount);
    localparam int sphereAddrWidth = $clog2(sphereCount);

    // Center xyz, half-size or radius, rgb
    localparam int rawWidth = 152;

    // Only this box follows the global offset
    localparam logic [indexWidth-1:0] movedBoxIndex = 8'd1;

    // ----------------------------------------
    // Built-in scene
    // ----------------------------------------
    // Per entry: x, y, z, half-size or radius, red, green, blue
    localparam int aabbScene [aabbCount][7] = '{
        '{0, -256, 0, 256, 100, 255, 100},
        '{0, 12, 24, 12, 255, 255, 145},
        '{-25, 12, 0, 12, 255, 70, 85},
        '{0, 0, 0, 0, 0, 0, 0}
    };
    localparam int sphereScene [sphereCount][7] = '{
        '{0, 16, 0, 16, 255, 255, 0},
        '{0, 0, 0, 0, 0, 0, 0}
    };

    typedef logic signed [fixedWidth-1:0] fixedT;

    typedef struct packed {
        fixedT x;
        fixedT y;
        fixedT z;
    } fixed3T;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb8T;

    typedef enum logic [1:0] {
        lambertian = 2'd0,
        metal      = 2'd1,
        dielectric = 2'd2
    } surfaceT;

    // Lanes cover startIndex + lane, valid below endIndex
    typedef struct packed {
        logic [indexWidth-1:0] startIndex;
        logic [indexWidth-1:0] endIndex;
    } queryT;

    typedef struct packed {
        fixed3T minCorner;
        fixed3T maxCorner;
    } aabbT;

    typedef struct packed {
        aabbT                  box;
        rgb8T                  color;
        surfaceT               surface;
        logic [indexWidth-1:0] index;
    } aabbPrimT;

    typedef struct packed {
        fixed3T                center;
        fixedT                 radius;
        rgb8T                  color;
        surfaceT               surface;
        logic [indexWidth-1:0] index;
    } spherePrimT;

    // Empty output lanes
    localparam aabbPrimT nullAabbPrim = '{
        box: '0, color: '0, surface: lambertian, index: nullIndex
    };
    localparam spherePrimT nullSpherePrim = '{
        center: '0, radius: '0, color: '0, surface: lambertian, index: nullIndex
    };

    // Refraction scene: entry 1 glass, entry 2 mirror, rest diffuse
    function automatic surfaceT surfaceOf(input logic [indexWidth-1:0] index);
        case (index)
            8'd1:    return dielectric;
            8'd2:    return metal;
            default: return lambertian;
        endcase
    endfunction

endpackage
